//--- tb.f
+incdir+common
common/cpu_pkg.sv
hw/instr_decoder.sv
hw/controller.sv
datapath/regfile.sv
datapath/alu_shift.sv
datapath/datapath.sv
hw/cpu_top.sv
tb/tb_cpu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CPU core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f tb.f -o sim_tb_cpu

./obj_dir/sim_tb_cpu 2>&1 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- tb/tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module tb_cpu;

    localparam int unsigned SEED = 32'hc6d4_d1be;
    localparam int CLK_PERIOD = 40;
    localparam int WATCHDOG_NS = 200 * 8 * CLK_PERIOD + 8 * CLK_PERIOD;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [`WORD_WIDTH-1:0]  instr;
    logic                    load;
    logic                    start;
    logic                    waiting;
    logic [`WORD_WIDTH-1:0]  result;
    logic                    z;
    logic                    n;
    logic                    v;

    // Expected architectural state.
    logic [`WORD_WIDTH-1:0]  model_regs [`NUM_REGS];
    logic [`WORD_WIDTH-1:0]  model_c;
    logic                    model_z;
    logic                    model_n;
    logic                    model_v;
    logic                    flags_hold;
    logic                    result_hold;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu_top cpu_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .load    (load),
        .start   (start),
        .waiting (waiting),
        .result  (result),
        .z       (z),
        .n       (n),
        .v       (v)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] expected,
            input logic [15:0] actual);
        $display("[ERROR] time %0t: %s expected 0x%04h, actual 0x%04h",
                 $time, name, expected, actual);
        abort_run("a value check failed");
    endtask

    // Only CMP may touch the flags; only ops that write C may touch result.
    a_flags_hold: assert property (@(posedge clk) disable iff (!rst_n)
        flags_hold |-> $stable({z, n, v}))
        else report_mismatch("znv", 16'($past({z, n, v})), 16'($sampled({z, n, v})));

    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        result_hold |-> $stable(result))
        else report_mismatch("result", $past(result), $sampled(result));

    function automatic logic [15:0] shift_val(input logic [15:0] b, input logic [1:0] sh);
        case (sh)
            2'd1:    return b << 1;
            2'd2:    return b >> 1;
            2'd3:    return {b[15], b[15:1]};
            default: return b;
        endcase
    endfunction

    function automatic logic [15:0] encode(input logic [2:0] opc, input logic [1:0] op,
            input logic [2:0] rn, input logic [2:0] rd, input logic [1:0] sh,
            input logic [2:0] rm);
        return {opc, op, rn, rd, sh, rm};
    endfunction

    function automatic logic [15:0] encode_mov_imm(input logic [2:0] rn, input logic [7:0] imm);
        return {cpu_pkg::OPC_MOV, cpu_pkg::ALU_AND, rn, imm};
    endfunction

    // Runs one instruction and checks it against the model.
    task automatic execute(input logic [15:0] word);
        logic [2:0]  opc;
        logic [1:0]  op;
        logic [15:0] a_val;
        logic [15:0] b_sh;
        logic [15:0] diff;
        int          sdiff;
        int          exp_cycles;
        int          cycles;
        logic        is_cmp;
        opc = word[15:13];
        op = word[12:11];
        a_val = model_regs[word[10:8]];
        b_sh = shift_val(model_regs[word[2:0]], word[4:3]);
        exp_cycles = 0;
        is_cmp = 1'b0;
        if (opc == 3'b110 && op == 2'd2) begin
            exp_cycles = 1;
            model_regs[word[10:8]] = {{8{word[7]}}, word[7:0]};
        end else if (opc == 3'b110 && op == 2'd0) begin
            exp_cycles = 3;
            model_c = b_sh;
        end else if (opc == 3'b101) begin
            exp_cycles = (op == 2'd3) ? 3 : 4;
            case (op)
                2'd0: model_c = a_val + b_sh;
                2'd1: begin
                    is_cmp = 1'b1;
                    diff = a_val - b_sh;
                    sdiff = int'($signed(a_val)) - int'($signed(b_sh));
                    model_z = (diff == 16'h0000);
                    model_n = diff[15];
                    model_v = (sdiff > 32767) || (sdiff < -32768);
                end
                2'd2: model_c = a_val & b_sh;
                default: model_c = ~b_sh;
            endcase
        end
        if (exp_cycles >= 3 && !is_cmp) begin
            model_regs[word[7:5]] = model_c;
        end

        @(posedge clk);
        instr <= word;
        load <= 1'b1;
        flags_hold <= !is_cmp;
        result_hold <= is_cmp || exp_cycles <= 1;
        @(posedge clk);
        load <= 1'b0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!waiting) begin
            cycles++;
            if (cycles > 16) begin
                abort_run("waiting stayed low for more than 16 cycles");
            end
            @(negedge clk);
        end

        assert (cycles == exp_cycles)
            else report_mismatch("busy cycles", 16'(exp_cycles), 16'(cycles));
        assert (result == model_c) else report_mismatch("result", model_c, result);
        assert (z == model_z) else report_mismatch("z", {15'b0, model_z}, {15'b0, z});
        assert (n == model_n) else report_mismatch("n", {15'b0, model_n}, {15'b0, n});
        assert (v == model_v) else report_mismatch("v", {15'b0, model_v}, {15'b0, v});
    endtask

    // Copies a register onto itself so it shows up in C.
    task automatic read_back(input logic [2:0] r);
        execute(encode(cpu_pkg::OPC_MOV, cpu_pkg::ALU_ADD, 3'd0, r, cpu_pkg::SH_NONE, r));
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired: the DUT hung or the tests ran too long");
    end

    initial begin
        logic [7:0]  imm;
        logic [1:0]  op;
        logic [2:0]  rd;
        int unsigned pick;
        void'($urandom(SEED));
        instr = '0;
        load = 1'b0;
        start = 1'b0;
        rst_n = 1'b0;
        flags_hold = 1'b0;
        result_hold = 1'b0;
        model_c = '0;
        model_z = 1'b0;
        model_n = 1'b0;
        model_v = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (waiting) else report_mismatch("waiting", 16'd1, {15'b0, waiting});
        assert (result == '0) else report_mismatch("result", 16'd0, result);
        assert ({z, n, v} == 3'b000) else report_mismatch("znv", 16'd0, {13'b0, z, n, v});

        // Half of the bytes are negative.
        for (int r = 0; r < 8; r++) begin
            imm = 8'($urandom());
            imm[7] = r[0];
            execute(encode_mov_imm(3'(r), imm));
        end
        for (int r = 0; r < 8; r++) begin
            read_back(3'(r));
        end

        for (int k = 0; k < 32; k++) begin
            pick = $urandom_range(2);
            op = (pick == 0) ? cpu_pkg::ALU_ADD :
                 (pick == 1) ? cpu_pkg::ALU_AND : cpu_pkg::ALU_MVN;
            rd = 3'($urandom_range(7));
            execute(encode(cpu_pkg::OPC_ALU, op, 3'($urandom_range(7)), rd, 2'(k),
                           3'($urandom_range(7))));
            read_back(rd);
        end

        // r4 = 0xffff, r5 = 0x7fff, r6 = 0x8000.
        execute(encode_mov_imm(3'd1, 8'd5));
        execute(encode_mov_imm(3'd2, 8'd5));
        execute(encode_mov_imm(3'd3, 8'd10));
        execute(encode_mov_imm(3'd4, 8'hff));
        execute(encode(cpu_pkg::OPC_MOV, cpu_pkg::ALU_ADD, 3'd0, 3'd5, cpu_pkg::SH_LSR1, 3'd4));
        execute(encode(cpu_pkg::OPC_ALU, cpu_pkg::ALU_MVN, 3'd0, 3'd6, cpu_pkg::SH_NONE, 3'd5));
        execute(encode_mov_imm(3'd7, 8'd1));
        execute(encode(cpu_pkg::OPC_ALU, cpu_pkg::ALU_CMP, 3'd1, 3'd0, cpu_pkg::SH_NONE, 3'd2));
        execute(encode(cpu_pkg::OPC_ALU, cpu_pkg::ALU_CMP, 3'd1, 3'd0, cpu_pkg::SH_NONE, 3'd3));
        execute(encode(cpu_pkg::OPC_ALU, cpu_pkg::ALU_CMP, 3'd5, 3'd0, cpu_pkg::SH_NONE, 3'd4));
        execute(encode(cpu_pkg::OPC_ALU, cpu_pkg::ALU_CMP, 3'd6, 3'd0, cpu_pkg::SH_NONE, 3'd7));
        execute(encode(cpu_pkg::OPC_ALU, cpu_pkg::ALU_CMP, 3'd6, 3'd0, cpu_pkg::SH_LSL1, 3'd4));
        for (int k = 0; k < 8; k++) begin
            execute(encode(cpu_pkg::OPC_ALU, cpu_pkg::ALU_CMP, 3'($urandom_range(7)), 3'd0,
                           2'(k), 3'($urandom_range(7))));
        end

        // Unsupported encodings stay in the wait state.
        execute({3'b111, 13'h0abc});
        execute(encode(cpu_pkg::OPC_MOV, cpu_pkg::ALU_CMP, 3'd2, 3'd3, 2'd0, 3'd4));
        execute(encode(cpu_pkg::OPC_MOV, cpu_pkg::ALU_MVN, 3'd5, 3'd6, 2'd1, 3'd7));

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`WORD_WIDTH-1:0] instr,
    input  wire logic                   load,
    input  wire logic                   start,
    output logic                        waiting,
    output logic [`WORD_WIDTH-1:0]      result,
    output logic                        z,
    output logic                        n,
    output logic                        v
);

    cpu_pkg::opcode_e            opcode;
    cpu_pkg::alu_op_e            alu_op;
    cpu_pkg::shift_op_e          shift_op;
    cpu_pkg::reg_sel_e           reg_sel;
    cpu_pkg::wb_sel_e            wb_sel;
    logic [`REG_IDX_WIDTH-1:0]   reg_idx;
    logic [`WORD_WIDTH-1:0]      sximm8;
    logic                        en_a;
    logic                        en_b;
    logic                        en_c;
    logic                        en_status;
    logic                        sel_a;
    logic                        w_en;

    instr_decoder instr_decoder_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .load     (load),
        .reg_sel  (reg_sel),
        .opcode   (opcode),
        .alu_op   (alu_op),
        .shift_op (shift_op),
        .reg_idx  (reg_idx),
        .sximm8   (sximm8)
    );

    controller controller_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .opcode    (opcode),
        .alu_op    (alu_op),
        .shift_op  (shift_op),
        .waiting   (waiting),
        .en_a      (en_a),
        .en_b      (en_b),
        .en_c      (en_c),
        .en_status (en_status),
        .sel_a     (sel_a),
        .w_en      (w_en),
        .reg_sel   (reg_sel),
        .wb_sel    (wb_sel)
    );

    datapath datapath_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en_a      (en_a),
        .en_b      (en_b),
        .en_c      (en_c),
        .en_status (en_status),
        .sel_a     (sel_a),
        .w_en      (w_en),
        .wb_sel    (wb_sel),
        .reg_idx   (reg_idx),
        .alu_op    (alu_op),
        .shift_op  (shift_op),
        .sximm8    (sximm8),
        .result    (result),
        .z         (z),
        .n         (n),
        .v         (v)
    );

endmodule

`default_nettype wire

//--- datapath/datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module datapath (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      en_a,
    input  wire logic                      en_b,
    input  wire logic                      en_c,
    input  wire logic                      en_status,
    input  wire logic                      sel_a,
    input  wire logic                      w_en,
    input  wire cpu_pkg::wb_sel_e          wb_sel,
    input  wire logic [`REG_IDX_WIDTH-1:0] reg_idx,
    input  wire cpu_pkg::alu_op_e          alu_op,
    input  wire cpu_pkg::shift_op_e        shift_op,
    input  wire logic [`WORD_WIDTH-1:0]    sximm8,
    output logic [`WORD_WIDTH-1:0]         result,
    output logic                           z,
    output logic                           n,
    output logic                           v
);

    logic [`WORD_WIDTH-1:0] rdata;
    logic [`WORD_WIDTH-1:0] wdata;
    logic [`WORD_WIDTH-1:0] a_reg;
    logic [`WORD_WIDTH-1:0] b_reg;
    logic [`WORD_WIDTH-1:0] c_reg;
    logic [`WORD_WIDTH-1:0] alu_in_a;
    logic [`WORD_WIDTH-1:0] alu_out;
    logic                   z_next;
    logic                   n_next;
    logic                   v_next;

    assign wdata = (wb_sel == cpu_pkg::WB_IMM8) ? sximm8 : c_reg;

    regfile regfile_i (
        .clk   (clk),
        .w_en  (w_en),
        .idx   (reg_idx),
        .wdata (wdata),
        .rdata (rdata)
    );

    // Zeroed A turns the ALU into a pass of the shifted B.
    assign alu_in_a = sel_a ? '0 : a_reg;

    alu_shift alu_shift_i (
        .a        (alu_in_a),
        .b        (b_reg),
        .alu_op   (alu_op),
        .shift_op (shift_op),
        .result   (alu_out),
        .z        (z_next),
        .n        (n_next),
        .v        (v_next)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_reg <= '0;
            b_reg <= '0;
            c_reg <= '0;
            z     <= 1'b0;
            n     <= 1'b0;
            v     <= 1'b0;
        end else begin
            if (en_a) a_reg <= rdata;
            if (en_b) b_reg <= rdata;
            if (en_c) c_reg <= alu_out;
            if (en_status) begin
                z <= z_next;
                n <= n_next;
                v <= v_next;
            end
        end
    end

    assign result = c_reg;

endmodule

`default_nettype wire

//--- datapath/alu_shift.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module alu_shift (
    input  wire logic [`WORD_WIDTH-1:0] a,
    input  wire logic [`WORD_WIDTH-1:0] b,
    input  wire cpu_pkg::alu_op_e       alu_op,
    input  wire cpu_pkg::shift_op_e     shift_op,
    output logic [`WORD_WIDTH-1:0]      result,
    output logic                        z,
    output logic                        n,
    output logic                        v
);

    localparam int MSB = `WORD_WIDTH - 1;

    logic [`WORD_WIDTH-1:0] b_sh;
    logic [`WORD_WIDTH-1:0] diff;

    always_comb begin
        case (shift_op)
            cpu_pkg::SH_LSL1: b_sh = {b[MSB-1:0], 1'b0};
            cpu_pkg::SH_LSR1: b_sh = {1'b0, b[MSB:1]};
            cpu_pkg::SH_ASR1: b_sh = {b[MSB], b[MSB:1]};
            default:          b_sh = b;
        endcase
    end

    assign diff = a - b_sh;

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: result = a + b_sh;
            cpu_pkg::ALU_CMP: result = diff;
            cpu_pkg::ALU_AND: result = a & b_sh;
            default:          result = ~b_sh;
        endcase
    end

    assign z = (result == '0);
    assign n = result[MSB];

    // Signed overflow of a - b when operand signs differ and the sign flips from a.
    assign v = (a[MSB] ^ b_sh[MSB]) & (diff[MSB] ^ a[MSB]);

endmodule

`default_nettype wire

//--- datapath/regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module regfile (
    input  wire logic                      clk,
    input  wire logic                      w_en,
    input  wire logic [`REG_IDX_WIDTH-1:0] idx,
    input  wire logic [`WORD_WIDTH-1:0]    wdata,
    output logic [`WORD_WIDTH-1:0]         rdata
);

    logic [`WORD_WIDTH-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (w_en) begin
            regs[idx] <= wdata;
        end
    end

    assign rdata = regs[idx];

endmodule

`default_nettype wire

//--- hw/controller.sv
`timescale 1ns/1ns
`default_nettype none

module controller (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    input  wire cpu_pkg::opcode_e     opcode,
    input  wire cpu_pkg::alu_op_e     alu_op,
    input  wire cpu_pkg::shift_op_e   shift_op,
    output logic                      waiting,
    output logic                      en_a,
    output logic                      en_b,
    output logic                      en_c,
    output logic                      en_status,
    output logic                      sel_a,
    output logic                      w_en,
    output cpu_pkg::reg_sel_e         reg_sel,
    output cpu_pkg::wb_sel_e          wb_sel
);

    cpu_pkg::state_e state;
    cpu_pkg::state_e start_state;

    // Entry state for the decoded instruction; unsupported pairs stay idle.
    always_comb begin
        start_state = cpu_pkg::ST_WAIT;
        if (opcode == cpu_pkg::OPC_ALU) begin
            case (alu_op)
                cpu_pkg::ALU_ADD: start_state = cpu_pkg::ST_ADD1;
                cpu_pkg::ALU_CMP: start_state = cpu_pkg::ST_CMP1;
                cpu_pkg::ALU_AND: start_state = cpu_pkg::ST_AND1;
                default:          start_state = cpu_pkg::ST_MVN1;
            endcase
        end else if (opcode == cpu_pkg::OPC_MOV) begin
            if (alu_op == cpu_pkg::ALU_AND) begin
                start_state = cpu_pkg::ST_MOV_IMM;
            end else if (alu_op == cpu_pkg::ALU_ADD) begin
                start_state = cpu_pkg::ST_MOV_R1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cpu_pkg::ST_WAIT;
        end else begin
            case (state)
                cpu_pkg::ST_WAIT:   state <= start ? start_state : cpu_pkg::ST_WAIT;
                cpu_pkg::ST_MOV_R1: state <= cpu_pkg::ST_MOV_R2;
                cpu_pkg::ST_MOV_R2: state <= cpu_pkg::ST_MOV_R3;
                cpu_pkg::ST_MVN1:   state <= cpu_pkg::ST_MVN2;
                cpu_pkg::ST_MVN2:   state <= cpu_pkg::ST_MVN3;
                cpu_pkg::ST_ADD1:   state <= cpu_pkg::ST_ADD2;
                cpu_pkg::ST_ADD2:   state <= cpu_pkg::ST_ADD3;
                cpu_pkg::ST_ADD3:   state <= cpu_pkg::ST_ADD4;
                cpu_pkg::ST_CMP1:   state <= cpu_pkg::ST_CMP2;
                cpu_pkg::ST_CMP2:   state <= cpu_pkg::ST_CMP3;
                cpu_pkg::ST_CMP3:   state <= cpu_pkg::ST_CMP4;
                cpu_pkg::ST_AND1:   state <= cpu_pkg::ST_AND2;
                cpu_pkg::ST_AND2:   state <= cpu_pkg::ST_AND3;
                cpu_pkg::ST_AND3:   state <= cpu_pkg::ST_AND4;
                default:            state <= cpu_pkg::ST_WAIT;
            endcase
        end
    end

    always_comb begin
        waiting   = 1'b0;
        en_a      = 1'b0;
        en_b      = 1'b0;
        en_c      = 1'b0;
        en_status = 1'b0;
        sel_a     = 1'b0;
        w_en      = 1'b0;
        reg_sel   = cpu_pkg::SEL_RM;
        wb_sel    = cpu_pkg::WB_C;
        case (state)
            cpu_pkg::ST_WAIT: waiting = 1'b1;
            cpu_pkg::ST_MOV_IMM: begin
                w_en    = 1'b1;
                reg_sel = cpu_pkg::SEL_RN;
                wb_sel  = cpu_pkg::WB_IMM8;
            end
            cpu_pkg::ST_ADD1, cpu_pkg::ST_CMP1, cpu_pkg::ST_AND1: begin
                en_a    = 1'b1;
                reg_sel = cpu_pkg::SEL_RN;
            end
            // Rm goes into B, then through the shifter.
            cpu_pkg::ST_ADD2, cpu_pkg::ST_CMP2, cpu_pkg::ST_AND2,
            cpu_pkg::ST_MOV_R1, cpu_pkg::ST_MVN1: en_b = 1'b1;
            cpu_pkg::ST_ADD3, cpu_pkg::ST_AND3: en_c = 1'b1;
            cpu_pkg::ST_MOV_R2, cpu_pkg::ST_MVN2: begin
                en_c  = 1'b1;
                sel_a = 1'b1;
            end
            cpu_pkg::ST_CMP4: en_status = 1'b1;
            cpu_pkg::ST_ADD4, cpu_pkg::ST_AND4,
            cpu_pkg::ST_MOV_R3, cpu_pkg::ST_MVN3: begin
                w_en    = 1'b1;
                reg_sel = cpu_pkg::SEL_RD;
            end
            default: ;
        endcase
    end

    a_wen_status_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(w_en && en_status));

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        state == cpu_pkg::ST_WAIT |-> !(en_a || en_b || en_c || en_status || w_en));

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module instr_decoder (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic [`WORD_WIDTH-1:0]    instr,
    input  wire logic                      load,
    input  wire cpu_pkg::reg_sel_e         reg_sel,
    output cpu_pkg::opcode_e               opcode,
    output cpu_pkg::alu_op_e               alu_op,
    output cpu_pkg::shift_op_e             shift_op,
    output logic [`REG_IDX_WIDTH-1:0]      reg_idx,
    output logic [`WORD_WIDTH-1:0]         sximm8
);

    logic [`WORD_WIDTH-1:0] ir;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (load) begin
            ir <= instr;
        end
    end

    assign opcode = cpu_pkg::opcode_e'(ir[15:13]);

    // The MOV register form encodes op 00, so the ALU adds the shifted Rm to zero.
    assign alu_op = cpu_pkg::alu_op_e'(ir[12:11]);

    assign shift_op = cpu_pkg::shift_op_e'(ir[4:3]);

    always_comb begin
        case (reg_sel)
            cpu_pkg::SEL_RN: reg_idx = ir[10:8];
            cpu_pkg::SEL_RD: reg_idx = ir[7:5];
            default:         reg_idx = ir[2:0];
        endcase
    end

    assign sximm8 = {{(`WORD_WIDTH-8){ir[7]}}, ir[7:0]};

endmodule

`default_nettype wire

//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef enum logic [2:0] {
        OPC_ALU = 3'b101,
        OPC_MOV = 3'b110
    } opcode_e;

    // Inside MOV, ALU_AND marks the immediate form and ALU_ADD the register form.
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_CMP = 2'd1,
        ALU_AND = 2'd2,
        ALU_MVN = 2'd3
    } alu_op_e;

    typedef enum logic [1:0] {
        SH_NONE = 2'd0,
        SH_LSL1 = 2'd1,
        SH_LSR1 = 2'd2,
        SH_ASR1 = 2'd3
    } shift_op_e;

    typedef enum logic [1:0] {
        SEL_RM = 2'd0,
        SEL_RD = 2'd1,
        SEL_RN = 2'd2
    } reg_sel_e;

    typedef enum logic [1:0] {
        WB_C    = 2'd0,
        WB_IMM8 = 2'd2
    } wb_sel_e;

    typedef enum logic [4:0] {
        ST_WAIT, ST_MOV_IMM,
        ST_MOV_R1, ST_MOV_R2, ST_MOV_R3,
        ST_MVN1, ST_MVN2, ST_MVN3,
        ST_ADD1, ST_ADD2, ST_ADD3, ST_ADD4,
        ST_CMP1, ST_CMP2, ST_CMP3, ST_CMP4,
        ST_AND1, ST_AND2, ST_AND3, ST_AND4
    } state_e;

endpackage

`default_nettype wire

//--- common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data word and instruction width.
`define WORD_WIDTH 16

`define NUM_REGS 8

`define REG_IDX_WIDTH 3

`endif
